// ==== common/ooo_consts.svh ====
// Sizing constants for the out-of-order core.
// Included by the shared package, the RTL that sizes arrays and the testbench.

`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// data word width
`define OOO_XLEN      32

// architectural registers, x0 reads zero
`define OOO_NUM_REGS  32

// reorder buffer slots, power of two so the pointers wrap on their own
`define OOO_ROB_DEPTH 8

// reservation station entries
`define OOO_RS_DEPTH  4

`endif

// ==== common/ooo_pkg.sv ====
// Shared types for the out-of-order core and its testbench.
// Widths follow the constants header.

`include "ooo_consts.svh"

package ooo_pkg;

  typedef logic [`OOO_XLEN-1:0] word_t;

  typedef logic [$clog2(`OOO_NUM_REGS)-1:0] reg_idx_t;

  // a reorder buffer slot number doubles as the rename tag
  typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_tag_t;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_SLT,
    OP_SLTU
  } alu_op_t;

endpackage

// ==== design/alu_unit.sv ====
// Common ALU, one operation per cycle with no back-pressure.
// The result is registered and driven onto the common data bus.

module alu_unit (
  input  logic              clk_in,
  input  logic              rst_n,
  input  logic              alu_valid,
  input  ooo_pkg::alu_op_t  alu_op,
  input  ooo_pkg::rob_tag_t alu_tag,
  input  ooo_pkg::word_t    alu_a,
  input  ooo_pkg::word_t    alu_b,
  output logic              cdb_valid,
  output ooo_pkg::rob_tag_t cdb_tag,
  output ooo_pkg::word_t    cdb_value
);
  import ooo_pkg::*;

  word_t      result;
  logic [4:0] shamt;

  // shifts use the low five bits only
  assign shamt = alu_b[4:0];

  always_comb begin
    case (alu_op)
      OP_ADD:  result = alu_a + alu_b;
      OP_SUB:  result = alu_a - alu_b;
      OP_AND:  result = alu_a & alu_b;
      OP_OR:   result = alu_a | alu_b;
      OP_XOR:  result = alu_a ^ alu_b;
      OP_SLL:  result = alu_a << shamt;
      OP_SRL:  result = alu_a >> shamt;
      OP_SRA:  result = word_t'($signed(alu_a) >>> shamt);
      OP_SLT:  result = word_t'($signed(alu_a) < $signed(alu_b));
      OP_SLTU: result = word_t'(alu_a < alu_b);
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= alu_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (alu_valid) begin
      cdb_tag   <= alu_tag;
      cdb_value <= result;
    end
  end

endmodule

// ==== design/register_file.sv ====
// Architectural register file with a busy flag and rename tag per register.
// Renames mark a register as owned by a reorder buffer slot; commits write
// the value and release the register if that slot is still the owner.

`include "ooo_consts.svh"

module register_file (
  input  logic              clk_in,
  input  logic              rst_n,
  input  ooo_pkg::reg_idx_t rd_addr1,
  input  ooo_pkg::reg_idx_t rd_addr2,
  output ooo_pkg::word_t    rd_value1,
  output ooo_pkg::word_t    rd_value2,
  output logic              rd_busy1,
  output logic              rd_busy2,
  output ooo_pkg::rob_tag_t rd_tag1,
  output ooo_pkg::rob_tag_t rd_tag2,
  input  logic              rename_valid,
  input  ooo_pkg::reg_idx_t rename_rd,
  input  ooo_pkg::rob_tag_t rename_tag,
  input  logic              commit_valid,
  input  ooo_pkg::reg_idx_t commit_rd,
  input  ooo_pkg::rob_tag_t commit_tag,
  input  ooo_pkg::word_t    commit_value
);
  import ooo_pkg::*;

  localparam int NREGS = `OOO_NUM_REGS;

  word_t            regs [NREGS];
  rob_tag_t         tags [NREGS];
  logic [NREGS-1:0] busy;

  // x0 never gets written or renamed, so it stays zero and idle
  assign rd_value1 = regs[rd_addr1];
  assign rd_value2 = regs[rd_addr2];
  assign rd_busy1  = busy[rd_addr1];
  assign rd_busy2  = busy[rd_addr2];
  assign rd_tag1   = tags[rd_addr1];
  assign rd_tag2   = tags[rd_addr2];

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      busy <= '0;
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
        tags[i] <= '0;
      end
    end else begin
      if (commit_valid && commit_rd != '0) begin
        regs[commit_rd] <= commit_value;
        // a newer rename keeps the register busy
        if (tags[commit_rd] == commit_tag) begin
          busy[commit_rd] <= 1'b0;
        end
      end
      // rename comes last so it wins the busy flag
      if (rename_valid && rename_rd != '0) begin
        busy[rename_rd] <= 1'b1;
        tags[rename_rd] <= rename_tag;
      end
    end
  end

endmodule

// ==== reservation_station/reservation_station.sv ====
// Reservation station in front of the common ALU.
// Entries wait on bus tags for missing operands; each cycle the oldest
// entry with both operands present goes to the ALU and frees its place.

`include "ooo_consts.svh"

module reservation_station (
  input  logic              clk_in,
  input  logic              rst_n,
  input  logic              rs_write,
  input  ooo_pkg::alu_op_t  rs_op,
  input  ooo_pkg::rob_tag_t rs_tag,
  input  ooo_pkg::word_t    rs_a,
  input  logic              rs_a_wait,
  input  ooo_pkg::rob_tag_t rs_a_tag,
  input  ooo_pkg::word_t    rs_b,
  input  logic              rs_b_wait,
  input  ooo_pkg::rob_tag_t rs_b_tag,
  output logic              rs_full,
  input  logic              cdb_valid,
  input  ooo_pkg::rob_tag_t cdb_tag,
  input  ooo_pkg::word_t    cdb_value,
  output logic              alu_valid,
  output ooo_pkg::alu_op_t  alu_op,
  output ooo_pkg::rob_tag_t alu_tag,
  output ooo_pkg::word_t    alu_a,
  output ooo_pkg::word_t    alu_b
);
  import ooo_pkg::*;

  localparam int DEPTH = `OOO_RS_DEPTH;
  localparam int IDX_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DEPTH-1:0] ent_valid;
  logic [DEPTH-1:0] ent_a_wait;
  logic [DEPTH-1:0] ent_b_wait;
  logic [IDX_W-1:0] ent_age   [DEPTH];
  alu_op_t          ent_op    [DEPTH];
  rob_tag_t         ent_tag   [DEPTH];
  rob_tag_t         ent_a_tag [DEPTH];
  rob_tag_t         ent_b_tag [DEPTH];
  word_t            ent_a     [DEPTH];
  word_t            ent_b     [DEPTH];

  logic [DEPTH-1:0] a_cap;
  logic [DEPTH-1:0] b_cap;
  logic [CNT_W-1:0] count;
  logic [IDX_W-1:0] sel;
  logic [IDX_W-1:0] sel_age;
  logic [IDX_W-1:0] free_idx;
  logic             found;
  logic             a_hit;
  logic             b_hit;

  // operand arriving on the bus in the very cycle it is written
  assign a_hit = rs_a_wait && cdb_valid && cdb_tag == rs_a_tag;
  assign b_hit = rs_b_wait && cdb_valid && cdb_tag == rs_b_tag;

  always_comb begin
    count    = '0;
    found    = 1'b0;
    sel      = '0;
    sel_age  = '0;
    free_idx = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!ent_valid[i]) begin
        free_idx = IDX_W'(i);
      end
    end
    for (int i = 0; i < DEPTH; i++) begin
      a_cap[i] = ent_a_wait[i] && cdb_valid && ent_a_tag[i] == cdb_tag;
      b_cap[i] = ent_b_wait[i] && cdb_valid && ent_b_tag[i] == cdb_tag;
      count    = count + CNT_W'(ent_valid[i]);
      // age 0 is the oldest
      if (ent_valid[i] && !ent_a_wait[i] && !ent_b_wait[i] &&
          (!found || ent_age[i] < sel_age)) begin
        found   = 1'b1;
        sel     = IDX_W'(i);
        sel_age = ent_age[i];
      end
    end
  end

  assign rs_full   = (count == CNT_W'(DEPTH));
  assign alu_valid = found;
  assign alu_op    = ent_op[sel];
  assign alu_tag   = ent_tag[sel];
  assign alu_a     = ent_a[sel];
  assign alu_b     = ent_b[sel];

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      ent_valid  <= '0;
      ent_a_wait <= '0;
      ent_b_wait <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        ent_age[i] <= '0;
      end
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        if (a_cap[i]) begin
          ent_a_wait[i] <= 1'b0;
        end
        if (b_cap[i]) begin
          ent_b_wait[i] <= 1'b0;
        end
        // younger entries move up when one leaves
        if (found && sel == IDX_W'(i)) begin
          ent_valid[i] <= 1'b0;
        end else if (found && ent_age[i] > sel_age) begin
          ent_age[i] <= ent_age[i] - 1'b1;
        end
      end
      if (rs_write) begin
        ent_valid[free_idx]  <= 1'b1;
        ent_a_wait[free_idx] <= rs_a_wait && !a_hit;
        ent_b_wait[free_idx] <= rs_b_wait && !b_hit;
        ent_age[free_idx]    <= IDX_W'(count - CNT_W'(found));
      end
    end
  end

  always_ff @(posedge clk_in) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (a_cap[i]) begin
        ent_a[i] <= cdb_value;
      end
      if (b_cap[i]) begin
        ent_b[i] <= cdb_value;
      end
    end
    if (rs_write) begin
      ent_op[free_idx]    <= rs_op;
      ent_tag[free_idx]   <= rs_tag;
      ent_a_tag[free_idx] <= rs_a_tag;
      ent_b_tag[free_idx] <= rs_b_tag;
      ent_a[free_idx]     <= a_hit ? cdb_value : rs_a;
      ent_b[free_idx]     <= b_hit ? cdb_value : rs_b;
    end
  end

endmodule

// ==== reorder_buffer/reorder_buffer.sv ====
// Reorder buffer, the control block of the core.
// Accepts instructions, renames the destination to a slot, resolves source
// operands for the station, records bus results and retires in order.

`include "ooo_consts.svh"

module reorder_buffer (
  input  logic              clk_in,
  input  logic              rst_n,
  input  logic              instr_valid,
  input  ooo_pkg::alu_op_t  instr_op,
  input  ooo_pkg::reg_idx_t instr_rd,
  input  ooo_pkg::reg_idx_t instr_rs1,
  input  ooo_pkg::reg_idx_t instr_rs2,
  input  ooo_pkg::word_t    instr_imm,
  input  logic              instr_use_imm,
  output logic              instr_ready,
  output ooo_pkg::reg_idx_t rd_addr1,
  output ooo_pkg::reg_idx_t rd_addr2,
  input  ooo_pkg::word_t    rd_value1,
  input  ooo_pkg::word_t    rd_value2,
  input  logic              rd_busy1,
  input  logic              rd_busy2,
  input  ooo_pkg::rob_tag_t rd_tag1,
  input  ooo_pkg::rob_tag_t rd_tag2,
  output logic              rename_valid,
  output ooo_pkg::reg_idx_t rename_rd,
  output ooo_pkg::rob_tag_t rename_tag,
  output logic              rs_write,
  output ooo_pkg::alu_op_t  rs_op,
  output ooo_pkg::rob_tag_t rs_tag,
  output ooo_pkg::word_t    rs_a,
  output logic              rs_a_wait,
  output ooo_pkg::rob_tag_t rs_a_tag,
  output ooo_pkg::word_t    rs_b,
  output logic              rs_b_wait,
  output ooo_pkg::rob_tag_t rs_b_tag,
  input  logic              rs_full,
  input  logic              cdb_valid,
  input  ooo_pkg::rob_tag_t cdb_tag,
  input  ooo_pkg::word_t    cdb_value,
  output logic              commit_valid,
  output ooo_pkg::reg_idx_t commit_rd,
  output ooo_pkg::rob_tag_t commit_tag,
  output ooo_pkg::word_t    commit_value
);
  import ooo_pkg::*;

  localparam int DEPTH = `OOO_ROB_DEPTH;
  localparam int CNT_W = $clog2(DEPTH + 1);

  reg_idx_t         slot_rd    [DEPTH];
  word_t            slot_value [DEPTH];
  logic [DEPTH-1:0] slot_done;
  rob_tag_t         head;
  rob_tag_t         tail;
  logic [CNT_W-1:0] count;
  logic             accept;

  // register value first, then a finished slot, then the bus this cycle
  function automatic void resolve(
    input  logic     busy,
    input  word_t    reg_value,
    input  rob_tag_t tag,
    output word_t    value,
    output logic     waiting
  );
    value   = reg_value;
    waiting = 1'b0;
    if (busy) begin
      if (slot_done[tag]) begin
        value = slot_value[tag];
      end else if (cdb_valid && cdb_tag == tag) begin
        value = cdb_value;
      end else begin
        waiting = 1'b1;
      end
    end
  endfunction

  assign instr_ready = (count != CNT_W'(DEPTH)) && !rs_full;
  assign accept      = instr_valid && instr_ready;

  assign rd_addr1 = instr_rs1;
  assign rd_addr2 = instr_rs2;

  // destination renamed to the tail slot
  assign rename_valid = accept;
  assign rename_rd    = instr_rd;
  assign rename_tag   = tail;

  assign rs_write = accept;
  assign rs_op    = instr_op;
  assign rs_tag   = tail;
  assign rs_a_tag = rd_tag1;
  assign rs_b_tag = rd_tag2;

  always_comb begin
    resolve(rd_busy1, rd_value1, rd_tag1, rs_a, rs_a_wait);
    resolve(rd_busy2, rd_value2, rd_tag2, rs_b, rs_b_wait);
    if (instr_use_imm) begin
      rs_b      = instr_imm;
      rs_b_wait = 1'b0;
    end
  end

  // head retires as soon as its result is in
  assign commit_valid = (count != '0) && slot_done[head];
  assign commit_rd    = slot_rd[head];
  assign commit_tag   = head;
  assign commit_value = slot_value[head];

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      slot_done <= '0;
    end else begin
      if (cdb_valid) begin
        slot_done[cdb_tag] <= 1'b1;
      end
      if (accept) begin
        slot_done[tail] <= 1'b0;
        tail            <= tail + 1'b1;
      end
      if (commit_valid) begin
        head <= head + 1'b1;
      end
      count <= count + CNT_W'(accept) - CNT_W'(commit_valid);
    end
  end

  always_ff @(posedge clk_in) begin
    if (accept) begin
      slot_rd[tail] <= instr_rd;
    end
    if (cdb_valid) begin
      slot_value[cdb_tag] <= cdb_value;
    end
  end

endmodule

// ==== design/ooo_core.sv ====
// Top level of the out-of-order integer core.
// Decoded ALU instructions enter on a valid/ready port; retired results
// leave in program order on the commit port.

module ooo_core (
  input  logic              clk_in,
  input  logic              rst_n,
  input  logic              instr_valid,
  input  ooo_pkg::alu_op_t  instr_op,
  input  ooo_pkg::reg_idx_t instr_rd,
  input  ooo_pkg::reg_idx_t instr_rs1,
  input  ooo_pkg::reg_idx_t instr_rs2,
  input  ooo_pkg::word_t    instr_imm,
  input  logic              instr_use_imm,
  output logic              instr_ready,
  output logic              commit_valid,
  output ooo_pkg::reg_idx_t commit_rd,
  output ooo_pkg::word_t    commit_value
);
  import ooo_pkg::*;

  // register file read
  reg_idx_t rd_addr1;
  reg_idx_t rd_addr2;
  word_t    rd_value1;
  word_t    rd_value2;
  logic     rd_busy1;
  logic     rd_busy2;
  rob_tag_t rd_tag1;
  rob_tag_t rd_tag2;

  // rename
  logic     rename_valid;
  reg_idx_t rename_rd;
  rob_tag_t rename_tag;

  // station entry
  logic     rs_write;
  alu_op_t  rs_op;
  rob_tag_t rs_tag;
  word_t    rs_a;
  logic     rs_a_wait;
  rob_tag_t rs_a_tag;
  word_t    rs_b;
  logic     rs_b_wait;
  rob_tag_t rs_b_tag;
  logic     rs_full;

  // dispatch to the ALU
  logic     alu_valid;
  alu_op_t  alu_op;
  rob_tag_t alu_tag;
  word_t    alu_a;
  word_t    alu_b;

  // common data bus
  logic     cdb_valid;
  rob_tag_t cdb_tag;
  word_t    cdb_value;

  rob_tag_t commit_tag;

  reorder_buffer rob (
    .clk_in        (clk_in),
    .rst_n         (rst_n),
    .instr_valid   (instr_valid),
    .instr_op      (instr_op),
    .instr_rd      (instr_rd),
    .instr_rs1     (instr_rs1),
    .instr_rs2     (instr_rs2),
    .instr_imm     (instr_imm),
    .instr_use_imm (instr_use_imm),
    .instr_ready   (instr_ready),
    .rd_addr1      (rd_addr1),
    .rd_addr2      (rd_addr2),
    .rd_value1     (rd_value1),
    .rd_value2     (rd_value2),
    .rd_busy1      (rd_busy1),
    .rd_busy2      (rd_busy2),
    .rd_tag1       (rd_tag1),
    .rd_tag2       (rd_tag2),
    .rename_valid  (rename_valid),
    .rename_rd     (rename_rd),
    .rename_tag    (rename_tag),
    .rs_write      (rs_write),
    .rs_op         (rs_op),
    .rs_tag        (rs_tag),
    .rs_a          (rs_a),
    .rs_a_wait     (rs_a_wait),
    .rs_a_tag      (rs_a_tag),
    .rs_b          (rs_b),
    .rs_b_wait     (rs_b_wait),
    .rs_b_tag      (rs_b_tag),
    .rs_full       (rs_full),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag),
    .cdb_value     (cdb_value),
    .commit_valid  (commit_valid),
    .commit_rd     (commit_rd),
    .commit_tag    (commit_tag),
    .commit_value  (commit_value)
  );

  reservation_station rs (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .rs_write  (rs_write),
    .rs_op     (rs_op),
    .rs_tag    (rs_tag),
    .rs_a      (rs_a),
    .rs_a_wait (rs_a_wait),
    .rs_a_tag  (rs_a_tag),
    .rs_b      (rs_b),
    .rs_b_wait (rs_b_wait),
    .rs_b_tag  (rs_b_tag),
    .rs_full   (rs_full),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_value (cdb_value),
    .alu_valid (alu_valid),
    .alu_op    (alu_op),
    .alu_tag   (alu_tag),
    .alu_a     (alu_a),
    .alu_b     (alu_b)
  );

  alu_unit alu (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .alu_valid (alu_valid),
    .alu_op    (alu_op),
    .alu_tag   (alu_tag),
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_value (cdb_value)
  );

  register_file rf (
    .clk_in       (clk_in),
    .rst_n        (rst_n),
    .rd_addr1     (rd_addr1),
    .rd_addr2     (rd_addr2),
    .rd_value1    (rd_value1),
    .rd_value2    (rd_value2),
    .rd_busy1     (rd_busy1),
    .rd_busy2     (rd_busy2),
    .rd_tag1      (rd_tag1),
    .rd_tag2      (rd_tag2),
    .rename_valid (rename_valid),
    .rename_rd    (rename_rd),
    .rename_tag   (rename_tag),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_tag   (commit_tag),
    .commit_value (commit_value)
  );

endmodule

// ==== verification/tb_ooo_core.sv ====
// Directed testbench for the out-of-order core.
// Sends instructions through the issue port, runs a sequential model of each
// one and compares every commit against the model in program order.

`include "ooo_consts.svh"

module tb_ooo_core;
  timeunit 1ns;
  timeprecision 1ps;

  import ooo_pkg::*;

  localparam int N_IMM    = 12;
  localparam int N_CHAIN  = 8;
  localparam int N_OOO    = 6;
  localparam int N_BURST  = 12;
  localparam int N_X0     = 3;
  localparam int N_RANDOM = 40;
  localparam int TOTAL_SENT = N_IMM + N_CHAIN + N_OOO + N_BURST + N_X0 + N_RANDOM;
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_SENT + 200;

  logic     clk_in = 1'b0;
  logic     rst_n;
  logic     instr_valid;
  alu_op_t  instr_op;
  reg_idx_t instr_rd;
  reg_idx_t instr_rs1;
  reg_idx_t instr_rs2;
  word_t    instr_imm;
  logic     instr_use_imm;
  logic     instr_ready;
  logic     commit_valid;
  reg_idx_t commit_rd;
  word_t    commit_value;

  // sequential model state and the commits it predicts
  word_t    model_regs [`OOO_NUM_REGS];
  reg_idx_t exp_rd [$];
  word_t    exp_value [$];
  int       sent_count   = 0;
  int       commits_seen = 0;
  int       stall_cycles = 0;
  int       cycle_count  = 0;

  ooo_core UUT (
    .clk_in        (clk_in),
    .rst_n         (rst_n),
    .instr_valid   (instr_valid),
    .instr_op      (instr_op),
    .instr_rd      (instr_rd),
    .instr_rs1     (instr_rs1),
    .instr_rs2     (instr_rs2),
    .instr_imm     (instr_imm),
    .instr_use_imm (instr_use_imm),
    .instr_ready   (instr_ready),
    .commit_valid  (commit_valid),
    .commit_rd     (commit_rd),
    .commit_value  (commit_value)
  );

  always #2 clk_in = ~clk_in;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, msg);
  endtask

  task automatic check_reg_idx(input reg_idx_t got, input reg_idx_t exp, input string what);
    if (got !== exp) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Some tests failed");
      $fatal(1, "register index mismatch");
    end
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("error at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      $display("Some tests failed");
      $fatal(1, "word mismatch");
    end
  endtask

  // expected ALU result from the operation definitions
  function automatic word_t ref_result(input alu_op_t op, input word_t a, input word_t b);
    logic [63:0] sign_ext;
    logic [4:0]  sh;
    sign_ext = {{32{a[31]}}, a};
    sh       = b[4:0];
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a + ~b + 32'd1;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << sh;
      OP_SRL:  return a >> sh;
      OP_SRA:  return word_t'(sign_ext >> sh);
      OP_SLT:  return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
      OP_SLTU: return {31'b0, a < b};
      default: return 'x;
    endcase
  endfunction

  // called just after a rising edge and returns just after the accepting edge
  task automatic send_instr(input alu_op_t op, input reg_idx_t rd, input reg_idx_t rs1,
                            input reg_idx_t rs2, input word_t imm, input logic use_imm);
    word_t a;
    word_t b;
    word_t value;
    a     = model_regs[rs1];
    b     = use_imm ? imm : model_regs[rs2];
    value = ref_result(op, a, b);
    if (rd != 0) begin
      model_regs[rd] = value;
    end
    exp_rd.push_back(rd);
    exp_value.push_back(value);
    sent_count++;
    instr_valid   = 1'b1;
    instr_op      = op;
    instr_rd      = rd;
    instr_rs1     = rs1;
    instr_rs2     = rs2;
    instr_imm     = imm;
    instr_use_imm = use_imm;
    @(negedge clk_in);
    while (!instr_ready) begin
      @(negedge clk_in);
    end
    @(posedge clk_in);
    #1;
  endtask

  task automatic drain_commits();
    instr_valid = 1'b0;
    while (exp_rd.size() != 0) begin
      @(posedge clk_in);
      #1;
    end
  endtask

  task automatic immediate_ops();
    send_instr(OP_ADD, 1, 0, 0, 32'h1234_5678, 1'b1);
    send_instr(OP_ADD, 2, 0, 0, 32'hf000_0005, 1'b1);
    // one of each operation on alternately positive and negative sources
    for (int i = 0; i < 10; i++) begin
      send_instr(alu_op_t'(i), reg_idx_t'(3 + i), reg_idx_t'(1 + i % 2), 0,
                 32'h0000_0f20 + i, 1'b1);
    end
    drain_commits();
  endtask

  task automatic dependency_chain();
    send_instr(OP_ADD, 13, 1, 2, 0, 1'b0);
    for (int i = 0; i < N_CHAIN - 1; i++) begin
      send_instr(alu_op_t'(i), 13, 13, 2, 0, 1'b0);
    end
    drain_commits();
  endtask

  task automatic out_of_order_commit();
    send_instr(OP_SUB, 14, 13, 1, 0, 1'b0);
    send_instr(OP_ADD, 15, 14, 14, 0, 1'b0);
    // waits on a result that itself waited, so its bus cycle comes late
    send_instr(OP_SLL, 15, 15, 0, 32'h0000_0003, 1'b1);
    // these three are free to run ahead of the chain above
    send_instr(OP_XOR, 16, 1, 0, 32'h00ff_00ff, 1'b1);
    send_instr(OP_OR, 17, 2, 0, 32'h0f0f_0000, 1'b1);
    send_instr(OP_SLTU, 18, 1, 2, 0, 1'b0);
    drain_commits();
  endtask

  task automatic back_pressure_burst();
    int first_stall;
    first_stall = stall_cycles;
    // a serial chain fills the station faster than it drains
    for (int i = 0; i < N_BURST; i++) begin
      send_instr((i % 3 == 0) ? OP_XOR : OP_ADD, 20, 20, 1, 0, 1'b0);
    end
    drain_commits();
    // a duplicated commit would land in this quiet window
    repeat (2 * `OOO_ROB_DEPTH) @(posedge clk_in);
    #1;
    if (stall_cycles == first_stall) begin
      report_failure("instr_ready never dropped during the back-pressure burst");
    end
  endtask

  task automatic zero_register();
    send_instr(OP_ADD, 0, 1, 0, 32'h0000_0055, 1'b1);
    send_instr(OP_ADD, 21, 0, 1, 0, 1'b0);
    send_instr(OP_SUB, 22, 1, 0, 0, 1'b0);
    drain_commits();
  endtask

  task automatic random_mix();
    for (int i = 0; i < N_RANDOM; i++) begin
      send_instr(alu_op_t'($urandom_range(9)), reg_idx_t'($urandom_range(31)),
                 reg_idx_t'($urandom_range(31)), reg_idx_t'($urandom_range(31)),
                 $urandom, $urandom_range(1) == 1);
    end
    drain_commits();
  endtask

  // outputs come from flops so the falling edge sees them settled
  always @(negedge clk_in) begin
    if (rst_n && commit_valid) begin
      if (exp_rd.size() == 0) begin
        report_failure("a commit arrived with no instruction outstanding");
      end else begin
        check_reg_idx(commit_rd, exp_rd.pop_front(), "commit_rd");
        check_word(commit_value, exp_value.pop_front(), "commit_value");
        commits_seen++;
      end
    end
    if (rst_n && instr_valid && !instr_ready) begin
      stall_cycles++;
    end
  end

  always @(posedge clk_in) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, commits stopped arriving", cycle_count);
      $display("Some tests failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst_n         = 1'b0;
    instr_valid   = 1'b0;
    instr_op      = OP_ADD;
    instr_rd      = '0;
    instr_rs1     = '0;
    instr_rs2     = '0;
    instr_imm     = '0;
    instr_use_imm = 1'b0;
    for (int i = 0; i < `OOO_NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    void'($urandom(386));
    repeat (10) @(posedge clk_in);
    #1;
    rst_n = 1'b1;
    if (!instr_ready) begin
      report_failure("instr_ready is low right after reset");
    end
    immediate_ops();
    dependency_chain();
    out_of_order_commit();
    back_pressure_burst();
    zero_register();
    random_mix();
    if (commits_seen == TOTAL_SENT && sent_count == TOTAL_SENT) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("sent %0d and committed %0d instructions", sent_count, commits_seen);
      $display("Some tests failed");
      $fatal(1, "commit count mismatch");
    end
  end

endmodule

// ==== tb.f ====
+incdir+common
common/ooo_pkg.sv
design/alu_unit.sv
design/register_file.sv
reservation_station/reservation_station.sv
reorder_buffer/reorder_buffer.sv
design/ooo_core.sv
verification/tb_ooo_core.sv

// ==== Bender.yml ====
package:
  name: ooo_core

export_include_dirs:
  - common

sources:
  - common/ooo_pkg.sv
  - design/alu_unit.sv
  - design/register_file.sv
  - reservation_station/reservation_station.sv
  - reorder_buffer/reorder_buffer.sv
  - design/ooo_core.sv
  - target: test
    files:
      - verification/tb_ooo_core.sv
